// ==== hdl/ctrlport_decoder.sv ====
`timescale 1ns/1ps

module ctrlport_decoder #(
  parameter int NUM_SLAVES   = 2,
  parameter logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] BASE_ADDR = '0,
  parameter int SLAVE_ADDR_W = 8
) (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,

  // Master side, one request stream in and one response out
  input  logic                                          s_req_wr,
  input  logic                                          s_req_rd,
  input  logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0]      s_req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]      s_req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0]   s_req_byte_en,
  input  logic                                          s_req_has_time,
  input  logic [ctrlport_pkg::CTRLPORT_TIME_W-1:0]      s_req_time,
  output logic                                          s_resp_ack,
  output logic [ctrlport_pkg::CTRLPORT_STS_W-1:0]       s_resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]      s_resp_data,

  // Slave side, every field packed with slave 0 in the lowest slice
  output logic [NUM_SLAVES-1:0]                                    m_req_wr,
  output logic [NUM_SLAVES-1:0]                                    m_req_rd,
  output logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_ADDR_W-1:0]      m_req_addr,
  output logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_DATA_W-1:0]      m_req_data,
  output logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0]   m_req_byte_en,
  output logic [NUM_SLAVES-1:0]                                    m_req_has_time,
  output logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_TIME_W-1:0]      m_req_time,
  input  logic [NUM_SLAVES-1:0]                                    m_resp_ack,
  input  logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_STS_W-1:0]       m_resp_status,
  input  logic [NUM_SLAVES*ctrlport_pkg::CTRLPORT_DATA_W-1:0]      m_resp_data
);

  import ctrlport_pkg::*;

  // Address layout from the top: base bits, port number, slave offset
  localparam int PORT_NUM_W = $clog2(NUM_SLAVES);
  localparam int BASE_POS   = SLAVE_ADDR_W + PORT_NUM_W;
  localparam logic [CTRLPORT_ADDR_W-1:0] BASE_MASK = {CTRLPORT_ADDR_W{1'b1}} << BASE_POS;

  // ------------------------------------------------------------------
  // Request split
  // ------------------------------------------------------------------

  // The base comparison is common to all slaves
  logic                  base_hit;
  logic [NUM_SLAVES-1:0] sel;

  assign base_hit = (s_req_addr & BASE_MASK) == (BASE_ADDR & BASE_MASK);

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_slave
    // With a single slave there are no port bits to look at
    if (PORT_NUM_W == 0) begin : gen_one
      assign sel[i] = base_hit;
    end else begin : gen_many
      assign sel[i] = base_hit &&
                      (s_req_addr[SLAVE_ADDR_W +: PORT_NUM_W] == PORT_NUM_W'(i));
    end

    // Strobes only go to the slave whose address range was hit
    always_ff @(posedge ctrlport_clk) begin
      if (ctrlport_rst) begin
        m_req_wr[i] <= 1'b0;
        m_req_rd[i] <= 1'b0;
      end else begin
        m_req_wr[i] <= s_req_wr & sel[i];
        m_req_rd[i] <= s_req_rd & sel[i];
      end
    end

    // Payload fans out to every slave and is qualified by the strobes
    always_ff @(posedge ctrlport_clk) begin
      m_req_data[CTRLPORT_DATA_W*i +: CTRLPORT_DATA_W]          <= s_req_data;
      m_req_byte_en[CTRLPORT_BYTE_EN_W*i +: CTRLPORT_BYTE_EN_W] <= s_req_byte_en;
      m_req_has_time[i]                                         <= s_req_has_time;
      m_req_time[CTRLPORT_TIME_W*i +: CTRLPORT_TIME_W]          <= s_req_time;
      // Slaves only see their own offset, base and port bits are cleared
      m_req_addr[CTRLPORT_ADDR_W*i +: CTRLPORT_ADDR_W] <=
        {{(CTRLPORT_ADDR_W-SLAVE_ADDR_W){1'b0}}, s_req_addr[SLAVE_ADDR_W-1:0]};
    end
  end

  // ------------------------------------------------------------------
  // Response merge
  // ------------------------------------------------------------------

  logic                       merged_ack;
  logic [CTRLPORT_STS_W-1:0]  merged_status;
  logic [CTRLPORT_DATA_W-1:0] merged_data;

  // Each slave contributes only in its ack cycle, so a plain OR is enough
  always_comb begin
    merged_ack    = 1'b0;
    merged_status = '0;
    merged_data   = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      merged_ack    = merged_ack | m_resp_ack[s];
      merged_status = merged_status |
        (m_resp_status[CTRLPORT_STS_W*s +: CTRLPORT_STS_W] & {CTRLPORT_STS_W{m_resp_ack[s]}});
      merged_data   = merged_data |
        (m_resp_data[CTRLPORT_DATA_W*s +: CTRLPORT_DATA_W] & {CTRLPORT_DATA_W{m_resp_ack[s]}});
    end
  end

  // Registered so the master never sees a path through the slave logic
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_resp_ack <= 1'b0;
    end else begin
      s_resp_ack <= merged_ack;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    s_resp_status <= merged_status;
    s_resp_data   <= merged_data;
  end

endmodule

// ==== hdl/ctrlport_pkg.sv ====
package ctrlport_pkg;

  // ------------------------------------------------------------------
  // Control-port field widths
  // ------------------------------------------------------------------

  localparam int CTRLPORT_ADDR_W    = 20;
  localparam int CTRLPORT_DATA_W    = 32;
  localparam int CTRLPORT_BYTE_EN_W = CTRLPORT_DATA_W / 8;
  localparam int CTRLPORT_TIME_W    = 64;
  localparam int CTRLPORT_STS_W     = 2;

  // ------------------------------------------------------------------
  // Response status codes
  // ------------------------------------------------------------------

  // Request completed normally
  localparam logic [CTRLPORT_STS_W-1:0] STS_OKAY    = 2'd0;
  // Unmapped offset, or a write to a read-only register
  localparam logic [CTRLPORT_STS_W-1:0] STS_CMDERR  = 2'd1;
  // Timed request arrived after its execution time
  localparam logic [CTRLPORT_STS_W-1:0] STS_TSERR   = 2'd2;
  // Reserved, no slave in this subsystem returns it
  localparam logic [CTRLPORT_STS_W-1:0] STS_WARNING = 2'd3;

  // Replace only the bytes of a word whose enable bit is set
  function automatic logic [CTRLPORT_DATA_W-1:0] byte_merge(
    input logic [CTRLPORT_DATA_W-1:0]    old_word,
    input logic [CTRLPORT_DATA_W-1:0]    new_word,
    input logic [CTRLPORT_BYTE_EN_W-1:0] byte_en
  );
    logic [CTRLPORT_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < CTRLPORT_BYTE_EN_W; b++) begin
      if (byte_en[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== hdl/ctrlport_reg_bank.sv ====
`timescale 1ns/1ps

module ctrlport_reg_bank #(
  parameter int NUM_REGS     = 16,
  parameter int SLAVE_ADDR_W = 8
) (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        req_wr,
  input  logic                                        req_rd,
  input  logic [SLAVE_ADDR_W-1:0]                     req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] req_byte_en,
  output logic                                        resp_ack,
  output logic [ctrlport_pkg::CTRLPORT_STS_W-1:0]     resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    resp_data
);

  import ctrlport_pkg::*;

  // Index width into the register array, at least one bit
  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [CTRLPORT_DATA_W-1:0] regs [NUM_REGS];
  logic                       in_range;
  logic [IDX_W-1:0]           idx;

  // Offsets past the last register are rejected
  assign in_range = int'(req_addr) < NUM_REGS;
  assign idx      = req_addr[IDX_W-1:0];

  // ------------------------------------------------------------------
  // Register storage
  // ------------------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (req_wr && in_range) begin
      // Bytes without an enable keep their old value
      regs[idx] <= byte_merge(regs[idx], req_data, req_byte_en);
    end
  end

  // ------------------------------------------------------------------
  // Response, one cycle after every strobe
  // ------------------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= req_wr | req_rd;
    end
  end

  // Status and data are only meaningful in the ack cycle
  always_ff @(posedge ctrlport_clk) begin
    if (!in_range) begin
      resp_status <= STS_CMDERR;
      resp_data   <= '0;
    end else begin
      resp_status <= STS_OKAY;
      // A write returns zero data, a read returns the stored word
      resp_data   <= req_rd ? regs[idx] : '0;
    end
  end

endmodule

// ==== hdl/ctrlport_reg_subsystem.sv ====
`timescale 1ns/1ps

module ctrlport_reg_subsystem #(
  parameter logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0] BASE_ADDR = 'h40000,
  parameter int SLAVE_ADDR_W = 8,
  parameter int NUM_REGS     = 16
) (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        req_wr,
  input  logic                                        req_rd,
  input  logic [ctrlport_pkg::CTRLPORT_ADDR_W-1:0]    req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] req_byte_en,
  input  logic                                        req_has_time,
  input  logic [ctrlport_pkg::CTRLPORT_TIME_W-1:0]    req_time,
  output logic                                        resp_ack,
  output logic [ctrlport_pkg::CTRLPORT_STS_W-1:0]     resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    resp_data
);

  import ctrlport_pkg::*;

  // Slave 0 is the register bank, slave 1 the timed-command block
  localparam int NUM_SLAVES = 2;

  // ------------------------------------------------------------------
  // Per-slave request and response vectors
  // ------------------------------------------------------------------

  logic [NUM_SLAVES-1:0]                    slv_req_wr;
  logic [NUM_SLAVES-1:0]                    slv_req_rd;
  logic [NUM_SLAVES*CTRLPORT_ADDR_W-1:0]    slv_req_addr;
  logic [NUM_SLAVES*CTRLPORT_DATA_W-1:0]    slv_req_data;
  logic [NUM_SLAVES*CTRLPORT_BYTE_EN_W-1:0] slv_req_byte_en;
  logic [NUM_SLAVES-1:0]                    slv_req_has_time;
  logic [NUM_SLAVES*CTRLPORT_TIME_W-1:0]    slv_req_time;
  logic [NUM_SLAVES-1:0]                    slv_resp_ack;
  logic [NUM_SLAVES*CTRLPORT_STS_W-1:0]     slv_resp_status;
  logic [NUM_SLAVES*CTRLPORT_DATA_W-1:0]    slv_resp_data;

  ctrlport_decoder #(
    .NUM_SLAVES   (NUM_SLAVES),
    .BASE_ADDR    (BASE_ADDR),
    .SLAVE_ADDR_W (SLAVE_ADDR_W)
  ) u_decoder (
    .ctrlport_clk   (ctrlport_clk),
    .ctrlport_rst   (ctrlport_rst),
    .s_req_wr       (req_wr),
    .s_req_rd       (req_rd),
    .s_req_addr     (req_addr),
    .s_req_data     (req_data),
    .s_req_byte_en  (req_byte_en),
    .s_req_has_time (req_has_time),
    .s_req_time     (req_time),
    .s_resp_ack     (resp_ack),
    .s_resp_status  (resp_status),
    .s_resp_data    (resp_data),
    .m_req_wr       (slv_req_wr),
    .m_req_rd       (slv_req_rd),
    .m_req_addr     (slv_req_addr),
    .m_req_data     (slv_req_data),
    .m_req_byte_en  (slv_req_byte_en),
    .m_req_has_time (slv_req_has_time),
    .m_req_time     (slv_req_time),
    .m_resp_ack     (slv_resp_ack),
    .m_resp_status  (slv_resp_status),
    .m_resp_data    (slv_resp_data)
  );

  // The bank has no timed behaviour, so its time fields stay unconnected
  ctrlport_reg_bank #(
    .NUM_REGS     (NUM_REGS),
    .SLAVE_ADDR_W (SLAVE_ADDR_W)
  ) u_reg_bank (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (slv_req_wr[0]),
    .req_rd       (slv_req_rd[0]),
    .req_addr     (slv_req_addr[0 +: SLAVE_ADDR_W]),
    .req_data     (slv_req_data[0 +: CTRLPORT_DATA_W]),
    .req_byte_en  (slv_req_byte_en[0 +: CTRLPORT_BYTE_EN_W]),
    .resp_ack     (slv_resp_ack[0]),
    .resp_status  (slv_resp_status[0 +: CTRLPORT_STS_W]),
    .resp_data    (slv_resp_data[0 +: CTRLPORT_DATA_W])
  );

  ctrlport_timed_cmd #(
    .SLAVE_ADDR_W (SLAVE_ADDR_W)
  ) u_timed_cmd (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (slv_req_wr[1]),
    .req_rd       (slv_req_rd[1]),
    .req_addr     (slv_req_addr[CTRLPORT_ADDR_W +: SLAVE_ADDR_W]),
    .req_data     (slv_req_data[CTRLPORT_DATA_W +: CTRLPORT_DATA_W]),
    .req_byte_en  (slv_req_byte_en[CTRLPORT_BYTE_EN_W +: CTRLPORT_BYTE_EN_W]),
    .req_has_time (slv_req_has_time[1]),
    .req_time     (slv_req_time[CTRLPORT_TIME_W +: CTRLPORT_TIME_W]),
    .resp_ack     (slv_resp_ack[1]),
    .resp_status  (slv_resp_status[CTRLPORT_STS_W +: CTRLPORT_STS_W]),
    .resp_data    (slv_resp_data[CTRLPORT_DATA_W +: CTRLPORT_DATA_W])
  );

endmodule

// ==== hdl/ctrlport_timed_cmd.sv ====
`timescale 1ns/1ps

module ctrlport_timed_cmd #(
  parameter int SLAVE_ADDR_W = 8
) (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        req_wr,
  input  logic                                        req_rd,
  input  logic [SLAVE_ADDR_W-1:0]                     req_addr,
  input  logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    req_data,
  input  logic [ctrlport_pkg::CTRLPORT_BYTE_EN_W-1:0] req_byte_en,
  input  logic                                        req_has_time,
  input  logic [ctrlport_pkg::CTRLPORT_TIME_W-1:0]    req_time,
  output logic                                        resp_ack,
  output logic [ctrlport_pkg::CTRLPORT_STS_W-1:0]     resp_status,
  output logic [ctrlport_pkg::CTRLPORT_DATA_W-1:0]    resp_data
);

  import ctrlport_pkg::*;

  // Register map
  localparam logic [SLAVE_ADDR_W-1:0] OFS_CNT_LO = SLAVE_ADDR_W'(0);
  localparam logic [SLAVE_ADDR_W-1:0] OFS_CNT_HI = SLAVE_ADDR_W'(1);
  localparam logic [SLAVE_ADDR_W-1:0] OFS_SCHED  = SLAVE_ADDR_W'(2);
  localparam logic [SLAVE_ADDR_W-1:0] OFS_STAMP  = SLAVE_ADDR_W'(3);

  logic [CTRLPORT_TIME_W-1:0]    counter;
  logic [CTRLPORT_DATA_W-1:0]    hi_latch;
  logic [CTRLPORT_DATA_W-1:0]    sched_reg;
  logic [CTRLPORT_DATA_W-1:0]    stamp;
  logic                          pend_valid;
  logic [CTRLPORT_TIME_W-1:0]    pend_time;
  logic [CTRLPORT_DATA_W-1:0]    pend_data;
  logic [CTRLPORT_BYTE_EN_W-1:0] pend_byte_en;

  logic                       is_sched;
  logic                       fire_pend;
  logic                       sched_wr;
  logic                       pend_start;
  logic                       ack_d;
  logic [CTRLPORT_STS_W-1:0]  sts_d;
  logic [CTRLPORT_DATA_W-1:0] data_d;

  assign is_sched  = req_addr == OFS_SCHED;
  // A parked write runs in the cycle where the counter reaches its time
  assign fire_pend = pend_valid && (pend_time == counter);

  // ------------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------------

  always_comb begin
    ack_d      = 1'b0;
    sts_d      = STS_OKAY;
    data_d     = '0;
    sched_wr   = 1'b0;
    pend_start = 1'b0;
    if (fire_pend) begin
      ack_d    = 1'b1;
      sched_wr = 1'b1;
    end else if (req_rd) begin
      // Reads never wait, even when a time is attached
      ack_d = 1'b1;
      case (req_addr)
        OFS_CNT_LO: data_d = counter[CTRLPORT_DATA_W-1:0];
        OFS_CNT_HI: data_d = hi_latch;
        OFS_SCHED:  data_d = sched_reg;
        OFS_STAMP:  data_d = stamp;
        default:    sts_d  = STS_CMDERR;
      endcase
    end else if (req_wr) begin
      if (!is_sched) begin
        ack_d = 1'b1;
        sts_d = STS_CMDERR;
      end else if (!req_has_time || (req_time == counter)) begin
        // Untimed, or due right now
        ack_d    = 1'b1;
        sched_wr = 1'b1;
      end else if (req_time < counter) begin
        ack_d = 1'b1;
        sts_d = STS_TSERR;
      end else begin
        pend_start = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Counter and register state
  // ------------------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      counter    <= '0;
      hi_latch   <= '0;
      sched_reg  <= '0;
      stamp      <= '0;
      pend_valid <= 1'b0;
      resp_ack   <= 1'b0;
    end else begin
      counter  <= counter + 1'b1;
      resp_ack <= ack_d;
      // Reading the low word freezes the high word for a coherent 64-bit read
      if (req_rd && (req_addr == OFS_CNT_LO)) begin
        hi_latch <= counter[CTRLPORT_TIME_W-1 -: CTRLPORT_DATA_W];
      end
      if (sched_wr) begin
        sched_reg <= fire_pend ? byte_merge(sched_reg, pend_data, pend_byte_en)
                               : byte_merge(sched_reg, req_data, req_byte_en);
        stamp     <= counter[CTRLPORT_DATA_W-1:0];
      end
      if (pend_start) begin
        pend_valid <= 1'b1;
      end else if (fire_pend) begin
        pend_valid <= 1'b0;
      end
    end
  end

  // Parked write payload and the response fields
  always_ff @(posedge ctrlport_clk) begin
    if (pend_start) begin
      pend_time    <= req_time;
      pend_data    <= req_data;
      pend_byte_en <= req_byte_en;
    end
    resp_status <= sts_d;
    resp_data   <= data_d;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ctrlport_reg_subsystem_tb \
  -f verilog.f -o ctrlport_sim

sim_out=$(./obj_dir/ctrlport_sim || true)
echo "$sim_out"

if grep -qF -- "** PASS **" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== test/ctrlport_reg_subsystem_checker.sv ====
`timescale 1ns/1ps

module ctrlport_reg_subsystem_checker (
  input logic       ctrlport_clk,
  input logic       ctrlport_rst,
  input logic       req_wr,
  input logic       req_rd,
  input logic [1:0] slv_req_wr,
  input logic [1:0] slv_req_rd,
  input logic [1:0] slv_resp_ack,
  input logic       resp_ack
);

  // Failed assertions so far, read by the testbench at the end of the run
  int assert_failures = 0;

  // A master request is either a read or a write, never both
  a_master_strobe: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    !(req_wr && req_rd))
    else begin
      $error("Master raised wr and rd in the same cycle");
      assert_failures = assert_failures + 1;
    end

  // Address ranges do not overlap, so at most one slave gets a strobe
  a_slave_strobe: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(slv_req_wr | slv_req_rd))
    else begin
      $error("Decoder strobed both slaves in one cycle");
      assert_failures = assert_failures + 1;
    end

  a_slave_ack: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(slv_resp_ack))
    else begin
      $error("Both slaves acked in the same cycle");
      assert_failures = assert_failures + 1;
    end

  // The merged ack is the registered OR of the slave acks
  a_resp_ack: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    resp_ack == $past(|slv_resp_ack))
    else begin
      $error("Master ack does not follow a slave ack by one cycle");
      assert_failures = assert_failures + 1;
    end

endmodule

bind ctrlport_reg_subsystem ctrlport_reg_subsystem_checker u_checker (
  .ctrlport_clk (ctrlport_clk),
  .ctrlport_rst (ctrlport_rst),
  .req_wr       (req_wr),
  .req_rd       (req_rd),
  .slv_req_wr   (slv_req_wr),
  .slv_req_rd   (slv_req_rd),
  .slv_resp_ack (slv_resp_ack),
  .resp_ack     (resp_ack)
);

// ==== test/ctrlport_reg_subsystem_tb.sv ====
`timescale 1ns/1ps

module ctrlport_reg_subsystem_tb;

  import ctrlport_pkg::*;

  // ------------------------------------------------------------------
  // Address map and limits
  // ------------------------------------------------------------------

  localparam logic [CTRLPORT_ADDR_W-1:0] BASE_ADDR = 20'h40000;
  localparam int SLAVE_ADDR_W = 8;
  localparam int NUM_REGS     = 16;

  // Bank at the base, timed-command block one slave window above it
  localparam logic [CTRLPORT_ADDR_W-1:0] BANK_BASE  = BASE_ADDR;
  localparam logic [CTRLPORT_ADDR_W-1:0] TIMED_BASE = BASE_ADDR + 20'h00100;

  localparam int ACK_WAIT   = 20;
  localparam int TIMED_WAIT = 400;
  // Roughly 300 requests over all tests, rounded up
  localparam int EXPECTED_REQ    = 320;
  localparam int WATCHDOG_CYCLES = 200 * EXPECTED_REQ + 2000;

  logic                          ctrlport_clk;
  logic                          ctrlport_rst;
  logic                          req_wr;
  logic                          req_rd;
  logic [CTRLPORT_ADDR_W-1:0]    req_addr;
  logic [CTRLPORT_DATA_W-1:0]    req_data;
  logic [CTRLPORT_BYTE_EN_W-1:0] req_byte_en;
  logic                          req_has_time;
  logic [CTRLPORT_TIME_W-1:0]    req_time;
  logic                          resp_ack;
  logic [CTRLPORT_STS_W-1:0]     resp_status;
  logic [CTRLPORT_DATA_W-1:0]    resp_data;

  int          errors;
  logic [31:0] lcg_state;
  logic [63:0] time_model;
  logic [31:0] bank_model [NUM_REGS];

  ctrlport_reg_subsystem #(
    .BASE_ADDR    (BASE_ADDR),
    .SLAVE_ADDR_W (SLAVE_ADDR_W),
    .NUM_REGS     (NUM_REGS)
  ) DUT (.*);

  initial begin
    ctrlport_clk = 1'b0;
    forever #4 ctrlport_clk = ~ctrlport_clk;
  end

  // Expected value of the free-running counter, zero in reset and +1 per cycle
  always @(posedge ctrlport_clk) begin
    if (ctrlport_rst) time_model <= 64'd0;
    else time_model <= time_model + 64'd1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ctrlport_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bit mask that covers every byte lane with its enable set
  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic report_mismatch(input string test, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
    $display("** Error %s (%s): expected 0x%0h, actual 0x%0h", test, field, expected, actual);
    errors++;
  endtask

  task automatic report_missing_ack(input string test, input logic [19:0] addr);
    $display("%s: the request to address 0x%05h got no ack in time", test, addr);
    errors++;
  endtask

  // One request, strobe for one cycle, then wait for the ack on falling edges
  task automatic bus_access(input logic wr, input logic [19:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input logic has_time, input logic [63:0] t,
                            input int max_wait, output logic [1:0] sts,
                            output logic [31:0] rdata, output int latency, output logic no_ack);
    int cycles;
    cycles  = 1;
    no_ack  = 1'b0;
    sts     = 2'd0;
    rdata   = 32'd0;
    latency = 0;
    @(posedge ctrlport_clk);
    req_wr       <= wr;
    req_rd       <= !wr;
    req_addr     <= addr;
    req_data     <= data;
    req_byte_en  <= be;
    req_has_time <= has_time;
    req_time     <= t;
    @(posedge ctrlport_clk);
    req_wr       <= 1'b0;
    req_rd       <= 1'b0;
    req_has_time <= 1'b0;
    while (1) begin
      @(negedge ctrlport_clk);
      if (resp_ack) break;
      if (cycles >= max_wait) begin
        no_ack = 1'b1;
        break;
      end
      cycles++;
    end
    if (!no_ack) begin
      sts     = resp_status;
      rdata   = resp_data;
      latency = cycles;
    end
  endtask

  task automatic read_word(input logic [19:0] addr, output logic [31:0] rdata,
                           output logic [1:0] sts, output int lat, output logic no_ack);
    bus_access(1'b0, addr, 32'd0, 4'h0, 1'b0, 64'd0, ACK_WAIT, sts, rdata, lat, no_ack);
  endtask

  task automatic write_word(input logic [19:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic [1:0] sts,
                            output int lat, output logic no_ack);
    logic [31:0] unused_data;
    bus_access(1'b1, addr, data, be, 1'b0, 64'd0, ACK_WAIT, sts, unused_data, lat, no_ack);
  endtask

  // Low word first, which latches the high word for the second read
  task automatic read_counter(input string test, output logic [63:0] value);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    read_word(TIMED_BASE, lo, sts, lat, na);
    if (na) report_missing_ack(test, TIMED_BASE);
    read_word(TIMED_BASE + 20'd1, hi, sts, lat, na);
    if (na) report_missing_ack(test, TIMED_BASE + 20'd1);
    if (sts != STS_OKAY) report_mismatch(test, "counter status", STS_OKAY, sts);
    if (lat != 3) report_mismatch(test, "counter latency", 3, lat);
    value = {hi, lo};
  endtask

  // Reads every bank register and compares it with the model
  task automatic compare_bank(input string test);
    logic [31:0] rd;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    for (int i = 0; i < NUM_REGS; i++) begin
      read_word(BANK_BASE + 20'(i), rd, sts, lat, na);
      if (na) begin
        report_missing_ack(test, BANK_BASE + 20'(i));
      end else begin
        if (rd != bank_model[i]) report_mismatch(test, "read data", bank_model[i], rd);
        if (sts != STS_OKAY) report_mismatch(test, "status", STS_OKAY, sts);
        if (lat != 3) report_mismatch(test, "latency", 3, lat);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  task automatic bank_access();
    logic [31:0] wd;
    logic [31:0] pd;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    // Registers come out of reset cleared
    compare_bank("bank_access");
    for (int i = 0; i < NUM_REGS; i++) begin
      wd = lcg_next();
      write_word(BANK_BASE + 20'(i), wd, 4'hF, sts, lat, na);
      bank_model[i] = wd;
      if (na) report_missing_ack("bank_access", BANK_BASE + 20'(i));
      else if (lat != 3) report_mismatch("bank_access", "write latency", 3, lat);
    end
    compare_bank("bank_access");
    // Lanes 0 and 2 only, the other two bytes must survive
    pd = 32'hA5C3_5A3C;
    write_word(BANK_BASE + 20'd5, pd, 4'b0101, sts, lat, na);
    bank_model[5] = (bank_model[5] & ~byte_mask(4'b0101)) | (pd & byte_mask(4'b0101));
    if (na) report_missing_ack("bank_access", BANK_BASE + 20'd5);
    compare_bank("bank_access");
  endtask

  task automatic command_errors();
    logic [31:0] rd;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    write_word(BANK_BASE + 20'(NUM_REGS), 32'hDEAD_BEEF, 4'hF, sts, lat, na);
    if (na) report_missing_ack("command_errors", BANK_BASE + 20'(NUM_REGS));
    else if (sts != STS_CMDERR) report_mismatch("command_errors", "status", STS_CMDERR, sts);
    read_word(BANK_BASE + 20'h0FF, rd, sts, lat, na);
    if (na) begin
      report_missing_ack("command_errors", BANK_BASE + 20'h0FF);
    end else begin
      if (sts != STS_CMDERR) report_mismatch("command_errors", "status", STS_CMDERR, sts);
      if (rd != 32'd0) report_mismatch("command_errors", "read data", 32'd0, rd);
    end
    compare_bank("command_errors");
    // The counter low word is read-only
    write_word(TIMED_BASE, 32'h1234_5678, 4'hF, sts, lat, na);
    if (na) report_missing_ack("command_errors", TIMED_BASE);
    else if (sts != STS_CMDERR) report_mismatch("command_errors", "status", STS_CMDERR, sts);
  endtask

  task automatic decode_isolation();
    logic [31:0] rd;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    write_word(BANK_BASE + 20'd2, 32'h1111_2222, 4'hF, sts, lat, na);
    bank_model[2] = 32'h1111_2222;
    write_word(TIMED_BASE + 20'd2, 32'h3333_4444, 4'hF, sts, lat, na);
    if (na) report_missing_ack("decode_isolation", TIMED_BASE + 20'd2);
    read_word(TIMED_BASE + 20'd2, rd, sts, lat, na);
    if (rd != 32'h3333_4444) report_mismatch("decode_isolation", "timed reg", 32'h3333_4444, rd);
    // A wrong base must reach neither slave, offset 5 in the bank included
    write_word(20'h00005, 32'hFFFF_FFFF, 4'hF, sts, lat, na);
    if (!na) begin
      $display("decode_isolation: a write to unmapped address 0x00005 was acked");
      errors++;
    end
    compare_bank("decode_isolation");
  endtask

  task automatic counter_reads();
    logic [63:0] c1;
    logic [63:0] c2;
    logic [63:0] t1;
    logic [63:0] t2;
    t1 = time_model;
    read_counter("counter_reads", c1);
    repeat (17) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    t2 = time_model;
    read_counter("counter_reads", c2);
    if (c2 <= c1) report_mismatch("counter_reads", "second value", c1 + 64'd1, c2);
    if ((c2 - c1) < (t2 - t1)) report_mismatch("counter_reads", "advance", t2 - t1, c2 - c1);
  endtask

  task automatic timed_writes();
    logic [63:0] now;
    logic [63:0] due;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [1:0]  sts;
    int          lat;
    logic        na;
    read_counter("timed_writes", now);
    due = now + 64'd100;
    wd  = lcg_next();
    bus_access(1'b1, TIMED_BASE + 20'd2, wd, 4'hF, 1'b1, due, TIMED_WAIT, sts, rd, lat, na);
    if (na) begin
      report_missing_ack("timed_writes", TIMED_BASE + 20'd2);
    end else begin
      if (sts != STS_OKAY) report_mismatch("timed_writes", "status", STS_OKAY, sts);
      if (time_model < due) report_mismatch("timed_writes", "ack time", due, time_model);
    end
    read_word(TIMED_BASE + 20'd2, rd, sts, lat, na);
    if (rd != wd) report_mismatch("timed_writes", "scheduled reg", wd, rd);
    read_word(TIMED_BASE + 20'd3, rd, sts, lat, na);
    if (rd != due[31:0]) report_mismatch("timed_writes", "write stamp", due[31:0], rd);
    // The counter is long past the earlier reading by now
    bus_access(1'b1, TIMED_BASE + 20'd2, ~wd, 4'hF, 1'b1, now, ACK_WAIT, sts, rd, lat, na);
    if (na) report_missing_ack("timed_writes", TIMED_BASE + 20'd2);
    else if (sts != STS_TSERR) report_mismatch("timed_writes", "late status", STS_TSERR, sts);
    read_word(TIMED_BASE + 20'd2, rd, sts, lat, na);
    if (rd != wd) report_mismatch("timed_writes", "after late write", wd, rd);
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [1:0]  sts;
    int          ofs;
    int          lat;
    logic        na;
    for (int n = 0; n < 200; n++) begin
      r   = lcg_next();
      ofs = int'(r[27:24]) % NUM_REGS;
      if (r[31]) begin
        wd = lcg_next();
        write_word(BANK_BASE + 20'(ofs), wd, r[19:16], sts, lat, na);
        bank_model[ofs] = (bank_model[ofs] & ~byte_mask(r[19:16])) | (wd & byte_mask(r[19:16]));
      end else begin
        read_word(BANK_BASE + 20'(ofs), rd, sts, lat, na);
        if (!na && (rd != bank_model[ofs])) begin
          report_mismatch("random_traffic", "read data", bank_model[ofs], rd);
        end
      end
      if (na) report_missing_ack("random_traffic", BANK_BASE + 20'(ofs));
      else if (sts != STS_OKAY) report_mismatch("random_traffic", "status", STS_OKAY, sts);
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin
    errors       = 0;
    lcg_state    = 32'd29;
    ctrlport_rst = 1'b1;
    req_wr       = 1'b0;
    req_rd       = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    req_byte_en  = '0;
    req_has_time = 1'b0;
    req_time     = '0;
    for (int i = 0; i < NUM_REGS; i++) bank_model[i] = 32'd0;
    repeat (8) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    bank_access();
    command_errors();
    decode_isolation();
    counter_reads();
    timed_writes();
    random_traffic();
    $display("Check errors: %0d, assertion failures: %0d", errors,
             DUT.u_checker.assert_failures);
    if ((errors == 0) && (DUT.u_checker.assert_failures == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/ctrlport_pkg.sv
hdl/ctrlport_decoder.sv
hdl/ctrlport_reg_bank.sv
hdl/ctrlport_timed_cmd.sv
hdl/ctrlport_reg_subsystem.sv
test/ctrlport_reg_subsystem_checker.sv
test/ctrlport_reg_subsystem_tb.sv
